// File: src/isa_pkg.sv
package isa_pkg;

	// operations the front end knows about
	typedef enum logic [3:0] {
		OP_NOP,
		OP_ADD,
		OP_ADDI,
		OP_LW,
		OP_SW,
		OP_SC,
		OP_BEQ,
		OP_J,
		OP_MUL,
		OP_DIV,
		OP_MFC0,
		OP_MTC0,
		OP_ERET
	} op_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fmt_t;

	// same 32 bits, register or immediate layout
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_word_t;

	localparam logic [5:0] opc_special  = 6'h00;
	localparam logic [5:0] opc_special2 = 6'h1c;
	localparam logic [5:0] opc_addi     = 6'h08;
	localparam logic [5:0] opc_lw       = 6'h23;
	localparam logic [5:0] opc_sw       = 6'h2b;
	localparam logic [5:0] opc_sc       = 6'h38;
	localparam logic [5:0] opc_beq      = 6'h04;
	localparam logic [5:0] opc_j        = 6'h02;
	localparam logic [5:0] opc_cop0     = 6'h10;

	localparam logic [5:0] funct_add  = 6'h20;
	localparam logic [5:0] funct_div  = 6'h1a;
	localparam logic [5:0] funct_mul  = 6'h02;
	localparam logic [5:0] funct_eret = 6'h18;

	// cop0 sub-op lives in the rs field
	localparam logic [4:0] cop0_mf = 5'h00;
	localparam logic [4:0] cop0_mt = 5'h04;
	localparam logic [4:0] cop0_co = 5'h10;

	// sll r0, r0, 1
	localparam logic [31:0] ssnop_word = 32'h40;

endpackage

// File: src/pipe_pkg.sv
package pipe_pkg;

	// issue logic is written for exactly two slots
	localparam int issue_num = 2;
	localparam int issue_cnt_w = $clog2(issue_num + 1);

	// cache stages after EX
	localparam int dcache_pipe_depth = 3;

	// serialize privileged ops against each other
	localparam bit cpu_mutex_priv = 1'b1;

	typedef struct packed {
		logic                 valid;
		isa_pkg::instr_word_t instr;
		logic [1:0]           iaddr_ex;
	} fetch_entry_t;

	typedef struct packed {
		isa_pkg::op_t op;
		logic [4:0]   rs1;
		logic [4:0]   rs2;
		logic [4:0]   rd;
		logic         is_load;
		logic         is_store;
		logic         is_controlflow;
		logic         is_priv;
		logic         is_nonrw_priv;
		logic         is_multicyc;
		// at decode: may run late; after issue: does run late
		logic         delayed_exec;
	} decoded_instr_t;

	typedef decoded_instr_t [issue_num-1:0] issue_pair_t;

endpackage

// File: src/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
	input  pipe_pkg::fetch_entry_t   entry,
	output pipe_pkg::decoded_instr_t decoded
);

	isa_pkg::instr_word_t instr;

	assign instr = entry.instr;

	always_comb begin
		decoded = '0;
		case (instr.i.opcode)
			isa_pkg::opc_special: begin
				case (instr.r.funct)
					isa_pkg::funct_add: begin
						decoded.op           = isa_pkg::OP_ADD;
						decoded.rs1          = instr.r.rs;
						decoded.rs2          = instr.r.rt;
						decoded.rd           = instr.r.rd;
						decoded.delayed_exec = 1'b1;
					end
					isa_pkg::funct_div: begin
						// result goes to hi/lo, no gpr written
						decoded.op          = isa_pkg::OP_DIV;
						decoded.rs1         = instr.r.rs;
						decoded.rs2         = instr.r.rt;
						decoded.is_multicyc = 1'b1;
					end
					// sll family, ssnop included, acts as nop
					default: decoded.op = isa_pkg::OP_NOP;
				endcase
			end
			isa_pkg::opc_special2: begin
				if (instr.r.funct == isa_pkg::funct_mul) begin
					decoded.op          = isa_pkg::OP_MUL;
					decoded.rs1         = instr.r.rs;
					decoded.rs2         = instr.r.rt;
					decoded.rd          = instr.r.rd;
					decoded.is_multicyc = 1'b1;
				end
			end
			isa_pkg::opc_addi: begin
				decoded.op           = isa_pkg::OP_ADDI;
				decoded.rs1          = instr.i.rs;
				decoded.rd           = instr.i.rt;
				decoded.delayed_exec = 1'b1;
			end
			isa_pkg::opc_lw: begin
				decoded.op      = isa_pkg::OP_LW;
				decoded.rs1     = instr.i.rs;
				decoded.rd      = instr.i.rt;
				decoded.is_load = 1'b1;
			end
			isa_pkg::opc_sw: begin
				// rs1 is the address, rs2 the store data
				decoded.op       = isa_pkg::OP_SW;
				decoded.rs1      = instr.i.rs;
				decoded.rs2      = instr.i.rt;
				decoded.is_store = 1'b1;
			end
			isa_pkg::opc_sc: begin
				// sc writes its success flag back into rt
				decoded.op       = isa_pkg::OP_SC;
				decoded.rs1      = instr.i.rs;
				decoded.rs2      = instr.i.rt;
				decoded.rd       = instr.i.rt;
				decoded.is_store = 1'b1;
			end
			isa_pkg::opc_beq: begin
				// compare runs on the alu, so it may resolve late
				decoded.op             = isa_pkg::OP_BEQ;
				decoded.rs1            = instr.i.rs;
				decoded.rs2            = instr.i.rt;
				decoded.is_controlflow = 1'b1;
				decoded.delayed_exec   = 1'b1;
			end
			isa_pkg::opc_j: begin
				decoded.op             = isa_pkg::OP_J;
				decoded.is_controlflow = 1'b1;
			end
			isa_pkg::opc_cop0: begin
				case (instr.r.rs)
					isa_pkg::cop0_mf: begin
						decoded.op      = isa_pkg::OP_MFC0;
						decoded.rd      = instr.r.rt;
						decoded.is_priv = 1'b1;
					end
					isa_pkg::cop0_mt: begin
						decoded.op      = isa_pkg::OP_MTC0;
						decoded.rs1     = instr.r.rt;
						decoded.is_priv = 1'b1;
					end
					isa_pkg::cop0_co: begin
						if (instr.r.funct == isa_pkg::funct_eret) begin
							decoded.op            = isa_pkg::OP_ERET;
							decoded.is_priv       = 1'b1;
							decoded.is_nonrw_priv = 1'b1;
						end
					end
					default: decoded.op = isa_pkg::OP_NOP;
				endcase
			end
			default: decoded.op = isa_pkg::OP_NOP;
		endcase

		// a fetch fault must be raised in order, never late
		if (entry.iaddr_ex != 2'b00)
			decoded.delayed_exec = 1'b0;
		if (!entry.valid)
			decoded = '0;
	end

endmodule

// File: src/instr_issue.sv
`timescale 1ns/1ps

module instr_issue (
	input  pipe_pkg::fetch_entry_t [pipe_pkg::issue_num-1:0]       fetch_entry,
	input  pipe_pkg::issue_pair_t                                  id_decoded,
	input  pipe_pkg::issue_pair_t                                  ex_decoded,
	input  pipe_pkg::issue_pair_t [pipe_pkg::dcache_pipe_depth-1:0] dcache_decoded,
	input  logic                                                   delayslot_not_exec,
	output pipe_pkg::issue_pair_t                                  issue_instr,
	output logic [pipe_pkg::issue_cnt_w-1:0]                       issue_num,
	output logic                                                   stall_req
);

	function automatic logic reads_reg(
		input pipe_pkg::decoded_instr_t id,
		input logic [4:0]               r
	);
		return r != 5'd0 && (id.rs1 == r || id.rs2 == r);
	endfunction

	// store data is only needed late, so it is skipped here
	function automatic logic reads_reg_early(
		input pipe_pkg::decoded_instr_t id,
		input logic [4:0]               r
	);
		return r != 5'd0 && (id.rs1 == r || (id.rs2 == r && !id.is_store));
	endfunction

	function automatic logic is_ssnop(input pipe_pkg::fetch_entry_t entry);
		return entry.valid && entry.instr == isa_pkg::ssnop_word;
	endfunction

	logic [1:0] valid;
	logic [1:0] mem_access;
	logic [1:0] can_delay;
	logic [1:0] taken;
	logic [1:0] ex_load_hit;
	logic [1:0] near_hazard;
	logic [1:0] mid_load_hit;
	logic       slot2_not_taken;
	logic       priv_in_flight;
	logic       nonrw_priv_in_flight;
	logic       priv_serialize;
	logic       branch_no_delayslot;
	logic       spec_branch;
	logic       spec_conflict;

	for (genvar i = 0; i < pipe_pkg::issue_num; i++) begin : gen_slot
		assign valid[i]      = fetch_entry[i].valid;
		assign mem_access[i] = id_decoded[i].is_load | id_decoded[i].is_store;
	end

	// second slot may only run late together with the first
	assign can_delay[0] = id_decoded[0].delayed_exec;
	assign can_delay[1] = id_decoded[0].delayed_exec & id_decoded[1].delayed_exec;

	assign slot2_not_taken =
		  !valid[1]
		| reads_reg(id_decoded[1], id_decoded[0].rd)
		| (mem_access[0] & mem_access[1])
		| delayslot_not_exec
		// branches only go out in the first slot
		| id_decoded[1].is_controlflow
		| is_ssnop(fetch_entry[0]) | is_ssnop(fetch_entry[1])
		| (id_decoded[0].op == isa_pkg::OP_SC) | (id_decoded[1].op == isa_pkg::OP_SC)
		| id_decoded[0].is_priv | id_decoded[1].is_priv
		| (id_decoded[0].is_multicyc & id_decoded[1].is_multicyc);

	assign taken = {!slot2_not_taken, 1'b1};

	// register hazards against everything still in flight
	always_comb begin
		ex_load_hit  = '0;
		near_hazard  = '0;
		mid_load_hit = '0;
		for (int i = 0; i < pipe_pkg::issue_num; i++) begin
			for (int j = 0; j < pipe_pkg::issue_num; j++) begin
				ex_load_hit[i] |= ex_decoded[j].is_load
					& reads_reg(id_decoded[i], ex_decoded[j].rd);
				near_hazard[i] |= dcache_decoded[0][j].is_load
					& reads_reg(id_decoded[i], dcache_decoded[0][j].rd);
				near_hazard[i] |= ex_decoded[j].delayed_exec
					& reads_reg(id_decoded[i], ex_decoded[j].rd);
				near_hazard[i] |= dcache_decoded[0][j].delayed_exec
					& reads_reg(id_decoded[i], dcache_decoded[0][j].rd);
				for (int k = 1; k < pipe_pkg::dcache_pipe_depth - 1; k++) begin
					mid_load_hit[i] |= dcache_decoded[k][j].is_load
						& reads_reg_early(id_decoded[i], dcache_decoded[k][j].rd);
				end
			end
		end
	end

	always_comb begin
		priv_in_flight       = 1'b0;
		nonrw_priv_in_flight = 1'b0;
		for (int j = 0; j < pipe_pkg::issue_num; j++) begin
			priv_in_flight       |= ex_decoded[j].is_priv;
			nonrw_priv_in_flight |= ex_decoded[j].is_nonrw_priv;
			for (int k = 0; k < pipe_pkg::dcache_pipe_depth; k++) begin
				priv_in_flight       |= dcache_decoded[k][j].is_priv;
				nonrw_priv_in_flight |= dcache_decoded[k][j].is_nonrw_priv;
			end
		end
	end

	assign priv_serialize = pipe_pkg::cpu_mutex_priv
		& (nonrw_priv_in_flight | (id_decoded[0].is_nonrw_priv & priv_in_flight));

	// delay slot not fetched yet
	assign branch_no_delayslot = id_decoded[0].is_controlflow & !valid[1];

	// a late branch may still redirect, so no stores or priv behind it
	assign spec_branch   = ex_decoded[0].is_controlflow & ex_decoded[0].delayed_exec;
	assign spec_conflict = id_decoded[0].is_store | id_decoded[1].is_store
		| id_decoded[0].is_priv | id_decoded[1].is_priv;

	assign stall_req =
		  |(ex_load_hit & taken)
		| |(near_hazard & taken & ~can_delay)
		| |(mid_load_hit & taken)
		| priv_serialize
		| branch_no_delayslot
		| (spec_branch & spec_conflict)
		| (valid == 2'b00);

	always_comb begin
		issue_instr = id_decoded;
		issue_num   = 2'd2;
		for (int i = 0; i < pipe_pkg::issue_num; i++)
			issue_instr[i].delayed_exec = near_hazard[i] & taken[i] & can_delay[i];
		if (slot2_not_taken) begin
			issue_instr[1] = '0;
			issue_num      = 2'd1;
		end
	end

endmodule

// File: src/pipe_tracker.sv
`timescale 1ns/1ps

module pipe_tracker (
	input  logic                                                   clk,
	input  logic                                                   arst_n,
	input  pipe_pkg::issue_pair_t                                  issue_instr,
	input  logic [pipe_pkg::issue_cnt_w-1:0]                       issue_num,
	input  logic                                                   stall_req,
	output pipe_pkg::issue_pair_t                                  ex_decoded,
	output pipe_pkg::issue_pair_t [pipe_pkg::dcache_pipe_depth-1:0] dcache_decoded
);

	pipe_pkg::issue_pair_t ex_next;

	// what enters EX this cycle
	always_comb begin
		ex_next = issue_instr;
		if (issue_num == 2'd1)
			ex_next[1] = '0;
		// bubble on stall
		if (stall_req)
			ex_next = '0;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_decoded <= '0;
		end else begin
			ex_decoded <= ex_next;
		end
	end

	// cache stages advance every cycle, never held
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dcache_decoded <= '0;
		end else begin
			dcache_decoded[0] <= ex_decoded;
			for (int k = 1; k < pipe_pkg::dcache_pipe_depth; k++)
				dcache_decoded[k] <= dcache_decoded[k-1];
		end
	end

endmodule

// File: src/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
	input  logic                                             clk,
	input  logic                                             arst_n,
	input  pipe_pkg::fetch_entry_t [pipe_pkg::issue_num-1:0] fetch_entry,
	input  logic                                             delayslot_not_exec,
	output pipe_pkg::issue_pair_t                            issue_instr,
	output logic [pipe_pkg::issue_cnt_w-1:0]                 issue_num,
	output logic                                             stall_req
);

	pipe_pkg::issue_pair_t                                  id_decoded;
	pipe_pkg::issue_pair_t                                  ex_decoded;
	pipe_pkg::issue_pair_t [pipe_pkg::dcache_pipe_depth-1:0] dcache_decoded;

	// one decoder per fetch slot
	for (genvar i = 0; i < pipe_pkg::issue_num; i++) begin : gen_decode
		instr_decode instr_decode_i (
			.entry   (fetch_entry[i]),
			.decoded (id_decoded[i])
		);
	end

	instr_issue instr_issue_i (
		.fetch_entry        (fetch_entry),
		.id_decoded         (id_decoded),
		.ex_decoded         (ex_decoded),
		.dcache_decoded     (dcache_decoded),
		.delayslot_not_exec (delayslot_not_exec),
		.issue_instr        (issue_instr),
		.issue_num          (issue_num),
		.stall_req          (stall_req)
	);

	pipe_tracker pipe_tracker_i (
		.clk            (clk),
		.arst_n         (arst_n),
		.issue_instr    (issue_instr),
		.issue_num      (issue_num),
		.stall_req      (stall_req),
		.ex_decoded     (ex_decoded),
		.dcache_decoded (dcache_decoded)
	);

endmodule

// File: verif/issue_stage_properties.sv
`timescale 1ns/1ps

module issue_stage_properties (
	input logic                                             clk,
	input logic                                             arst_n,
	input pipe_pkg::fetch_entry_t [pipe_pkg::issue_num-1:0] fetch_entry,
	input pipe_pkg::issue_pair_t                            issue_instr,
	input logic [pipe_pkg::issue_cnt_w-1:0]                 issue_num,
	input logic                                             stall_req
);

	num_in_range: assert property (@(posedge clk) disable iff (!arst_n)
		issue_num == 2'd1 || issue_num == 2'd2)
		else $error("issue_num outside 1..2");

	// single issue leaves the second slot empty
	slot1_empty: assert property (@(posedge clk) disable iff (!arst_n)
		issue_num == 2'd1 |-> issue_instr[1] == '0)
		else $error("slot 1 not zero on single issue");

	empty_fetch_stalls: assert property (@(posedge clk) disable iff (!arst_n)
		!fetch_entry[0].valid && !fetch_entry[1].valid |-> stall_req)
		else $error("no stall with both fetch slots invalid");

endmodule

// File: verif/issue_stage_tb.sv
`timescale 1ns/1ps

module issue_stage_tb;

	localparam int n_cycles      = 500;
	localparam int timeout_limit = 4 * n_cycles;

	// one generated instruction, kept next to its encoding
	typedef struct packed {
		logic         valid;
		logic         ssnop;
		logic [1:0]   iaddr_ex;
		isa_pkg::op_t op;
		logic [4:0]   rs;
		logic [4:0]   rt;
		logic [4:0]   rd;
	} slot_gen_t;

	logic                                             clk = 1'b0;
	logic                                             arst_n;
	pipe_pkg::fetch_entry_t [pipe_pkg::issue_num-1:0] fetch_entry;
	logic                                             delayslot_not_exec;
	pipe_pkg::issue_pair_t                            issue_instr;
	logic [pipe_pkg::issue_cnt_w-1:0]                 issue_num;
	logic                                             stall_req;

	logic [15:0] lfsr;
	int          cycle_count = 0;
	slot_gen_t   slot [2];
	logic        next_ds;

	// reference model state
	pipe_pkg::issue_pair_t            m_ex;
	pipe_pkg::issue_pair_t            m_dc [pipe_pkg::dcache_pipe_depth];
	pipe_pkg::issue_pair_t            exp_instr;
	logic [pipe_pkg::issue_cnt_w-1:0] exp_num;
	logic                             exp_stall;

	issue_stage issue_stage_i (
		.clk                (clk),
		.arst_n             (arst_n),
		.fetch_entry        (fetch_entry),
		.delayslot_not_exec (delayslot_not_exec),
		.issue_instr        (issue_instr),
		.issue_num          (issue_num),
		.stall_req          (stall_req)
	);

	bind issue_stage issue_stage_properties issue_stage_properties_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.fetch_entry (fetch_entry),
		.issue_instr (issue_instr),
		.issue_num   (issue_num),
		.stall_req   (stall_req)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("timeout: run did not finish within %0d cycles", timeout_limit);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [15:0] draw(input int nbits);
		logic [15:0] val;
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = lfsr_next(lfsr);
			val  = {val[14:0], lfsr[0]};
		end
		return val;
	endfunction

	// small register pool so hazards show up often
	function automatic slot_gen_t gen_slot(input logic allow_invalid);
		slot_gen_t  g;
		logic [3:0] cls;
		g       = '0;
		g.valid = 1'b1;
		g.rs    = 5'(draw(2));
		g.rt    = 5'(draw(2));
		g.rd    = 5'(draw(2));
		cls     = 4'(draw(4));
		case (cls)
			4'd0, 4'd1, 4'd2, 4'd3: g.op = isa_pkg::OP_ADD;
			4'd4, 4'd5:             g.op = isa_pkg::OP_ADDI;
			4'd6, 4'd7:             g.op = isa_pkg::OP_LW;
			4'd8:                   g.op = isa_pkg::OP_SW;
			4'd9:                   g.op = isa_pkg::OP_SC;
			4'd10:                  g.op = isa_pkg::OP_BEQ;
			4'd11:                  g.op = isa_pkg::OP_J;
			4'd12:                  g.op = isa_pkg::OP_MUL;
			4'd13:                  g.op = isa_pkg::OP_DIV;
			4'd14:                  g.op = draw(1) != 16'd0 ? isa_pkg::OP_MTC0 : isa_pkg::OP_MFC0;
			default: begin
				if (draw(1) != 16'd0) begin
					g.op = isa_pkg::OP_ERET;
				end else begin
					g.op    = isa_pkg::OP_NOP;
					g.ssnop = 1'b1;
				end
			end
		endcase
		if (allow_invalid && draw(4) == 16'd0)
			g.valid = 1'b0;
		// a rare fetch fault, which forbids late execution
		if (draw(4) == 16'd0)
			g.iaddr_ex = 2'b01 + 2'(draw(1));
		return g;
	endfunction

	function automatic pipe_pkg::fetch_entry_t encode(input slot_gen_t g);
		pipe_pkg::fetch_entry_t e;
		e          = '0;
		e.valid    = g.valid;
		e.iaddr_ex = g.iaddr_ex;
		case (g.op)
			isa_pkg::OP_ADD:  e.instr = {isa_pkg::opc_special, g.rs, g.rt, g.rd, 5'd0,
				isa_pkg::funct_add};
			isa_pkg::OP_ADDI: e.instr = {isa_pkg::opc_addi, g.rs, g.rt, 16'h0010};
			isa_pkg::OP_LW:   e.instr = {isa_pkg::opc_lw, g.rs, g.rt, 16'h0004};
			isa_pkg::OP_SW:   e.instr = {isa_pkg::opc_sw, g.rs, g.rt, 16'h0008};
			isa_pkg::OP_SC:   e.instr = {isa_pkg::opc_sc, g.rs, g.rt, 16'h000c};
			isa_pkg::OP_BEQ:  e.instr = {isa_pkg::opc_beq, g.rs, g.rt, 16'h0020};
			isa_pkg::OP_J:    e.instr = {isa_pkg::opc_j, 26'h40};
			isa_pkg::OP_MUL:  e.instr = {isa_pkg::opc_special2, g.rs, g.rt, g.rd, 5'd0,
				isa_pkg::funct_mul};
			isa_pkg::OP_DIV:  e.instr = {isa_pkg::opc_special, g.rs, g.rt, 10'd0,
				isa_pkg::funct_div};
			isa_pkg::OP_MFC0: e.instr = {isa_pkg::opc_cop0, isa_pkg::cop0_mf, g.rt, g.rd, 11'd0};
			isa_pkg::OP_MTC0: e.instr = {isa_pkg::opc_cop0, isa_pkg::cop0_mt, g.rt, g.rd, 11'd0};
			isa_pkg::OP_ERET: e.instr = {isa_pkg::opc_cop0, isa_pkg::cop0_co, 15'd0,
				isa_pkg::funct_eret};
			default:          e.instr = g.ssnop ? isa_pkg::ssnop_word : 32'h0;
		endcase
		return e;
	endfunction

	// expected decode straight from the op class
	function automatic pipe_pkg::decoded_instr_t expect_decode(input slot_gen_t g);
		pipe_pkg::decoded_instr_t d;
		d    = '0;
		d.op = g.op;
		case (g.op)
			isa_pkg::OP_ADD: begin
				d.rs1          = g.rs;
				d.rs2          = g.rt;
				d.rd           = g.rd;
				d.delayed_exec = 1'b1;
			end
			isa_pkg::OP_ADDI: begin
				d.rs1          = g.rs;
				d.rd           = g.rt;
				d.delayed_exec = 1'b1;
			end
			isa_pkg::OP_LW: begin
				d.rs1     = g.rs;
				d.rd      = g.rt;
				d.is_load = 1'b1;
			end
			isa_pkg::OP_SW, isa_pkg::OP_SC: begin
				d.rs1      = g.rs;
				d.rs2      = g.rt;
				d.rd       = g.op == isa_pkg::OP_SC ? g.rt : 5'd0;
				d.is_store = 1'b1;
			end
			isa_pkg::OP_BEQ: begin
				d.rs1            = g.rs;
				d.rs2            = g.rt;
				d.is_controlflow = 1'b1;
				d.delayed_exec   = 1'b1;
			end
			isa_pkg::OP_J: d.is_controlflow = 1'b1;
			isa_pkg::OP_MUL, isa_pkg::OP_DIV: begin
				d.rs1         = g.rs;
				d.rs2         = g.rt;
				d.rd          = g.op == isa_pkg::OP_MUL ? g.rd : 5'd0;
				d.is_multicyc = 1'b1;
			end
			isa_pkg::OP_MFC0: begin
				d.rd      = g.rt;
				d.is_priv = 1'b1;
			end
			isa_pkg::OP_MTC0: begin
				d.rs1     = g.rt;
				d.is_priv = 1'b1;
			end
			isa_pkg::OP_ERET: begin
				d.is_priv       = 1'b1;
				d.is_nonrw_priv = 1'b1;
			end
			default: d = '0;
		endcase
		// a faulting fetch is never executed late
		if (g.iaddr_ex != 2'b00)
			d.delayed_exec = 1'b0;
		if (!g.valid)
			d = '0;
		return d;
	endfunction

	// skip_data leaves out the data operand of a store
	function automatic logic reads(
		input pipe_pkg::decoded_instr_t c,
		input logic [4:0]               r,
		input logic                     skip_data
	);
		if (r == 5'd0)
			return 1'b0;
		return c.rs1 == r || (c.rs2 == r && !(skip_data && c.is_store));
	endfunction

	task automatic predict();
		pipe_pkg::issue_pair_t id;
		logic [1:0] take;
		logic [1:0] delayable;
		logic       single;
		logic       ssnop_any;
		logic       ld_ex;
		logic       near;
		logic       mid;
		logic       priv_any;
		logic       nonrw_any;
		id[0]     = expect_decode(slot[0]);
		id[1]     = expect_decode(slot[1]);
		ssnop_any = (slot[0].valid && slot[0].ssnop) || (slot[1].valid && slot[1].ssnop);
		single    = !slot[1].valid || reads(id[1], id[0].rd, 1'b0)
			|| ((id[0].is_load || id[0].is_store) && (id[1].is_load || id[1].is_store))
			|| delayslot_not_exec || id[1].is_controlflow || ssnop_any
			|| id[0].op == isa_pkg::OP_SC || id[1].op == isa_pkg::OP_SC
			|| id[0].is_priv || id[1].is_priv
			|| (id[0].is_multicyc && id[1].is_multicyc);
		take      = {!single, 1'b1};
		delayable = {id[0].delayed_exec && id[1].delayed_exec, id[0].delayed_exec};
		exp_stall = 1'b0;
		exp_instr = id;
		for (int s = 0; s < 2; s++) begin
			ld_ex = 1'b0;
			near  = 1'b0;
			mid   = 1'b0;
			for (int j = 0; j < 2; j++) begin
				ld_ex |= m_ex[j].is_load && reads(id[s], m_ex[j].rd, 1'b0);
				near  |= m_dc[0][j].is_load && reads(id[s], m_dc[0][j].rd, 1'b0);
				near  |= m_ex[j].delayed_exec && reads(id[s], m_ex[j].rd, 1'b0);
				near  |= m_dc[0][j].delayed_exec && reads(id[s], m_dc[0][j].rd, 1'b0);
				for (int k = 1; k < pipe_pkg::dcache_pipe_depth - 1; k++)
					mid |= m_dc[k][j].is_load && reads(id[s], m_dc[k][j].rd, 1'b1);
			end
			if (take[s])
				exp_stall |= ld_ex || mid || (near && !delayable[s]);
			exp_instr[s].delayed_exec = near && take[s] && delayable[s];
		end
		priv_any  = 1'b0;
		nonrw_any = 1'b0;
		for (int j = 0; j < 2; j++) begin
			priv_any  |= m_ex[j].is_priv;
			nonrw_any |= m_ex[j].is_nonrw_priv;
			for (int k = 0; k < pipe_pkg::dcache_pipe_depth; k++) begin
				priv_any  |= m_dc[k][j].is_priv;
				nonrw_any |= m_dc[k][j].is_nonrw_priv;
			end
		end
		exp_stall |= pipe_pkg::cpu_mutex_priv && (nonrw_any || (id[0].is_nonrw_priv && priv_any));
		exp_stall |= id[0].is_controlflow && !slot[1].valid;
		exp_stall |= m_ex[0].is_controlflow && m_ex[0].delayed_exec
			&& (id[0].is_store || id[1].is_store || id[0].is_priv || id[1].is_priv);
		exp_stall |= !slot[0].valid && !slot[1].valid;
		exp_num = 2'd2;
		if (single) begin
			exp_instr[1] = '0;
			exp_num      = 2'd1;
		end
	endtask

	// the tracker as seen after the next rising edge
	task automatic advance();
		for (int k = pipe_pkg::dcache_pipe_depth - 1; k > 0; k--)
			m_dc[k] = m_dc[k-1];
		m_dc[0] = m_ex;
		if (exp_stall)
			m_ex = '0;
		else
			m_ex = exp_instr;
	endtask

	task automatic next_inputs();
		if (!exp_stall) begin
			if (exp_num == 2'd1 && slot[1].valid) begin
				slot[0] = slot[1];
				slot[1] = gen_slot(1'b1);
			end else begin
				slot[0] = gen_slot(1'b0);
				slot[1] = gen_slot(1'b1);
				// an empty fetch now and then
				if (draw(5) == 16'd0) begin
					slot[0].valid = 1'b0;
					slot[1].valid = 1'b0;
				end
			end
			next_ds = draw(3) == 16'd0;
		end else begin
			// missing slots arrive while stalled
			if (!slot[0].valid)
				slot[0] = gen_slot(1'b0);
			if (!slot[1].valid)
				slot[1] = gen_slot(1'b0);
		end
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED: %s got %h expected %h", name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	initial begin
		lfsr               = 16'd25696;
		arst_n             = 1'b0;
		fetch_entry        = '0;
		delayslot_not_exec = 1'b0;
		next_ds            = 1'b0;
		m_ex               = '0;
		for (int k = 0; k < pipe_pkg::dcache_pipe_depth; k++)
			m_dc[k] = '0;
		// independent alu pair right after reset
		slot[0]       = '0;
		slot[0].valid = 1'b1;
		slot[0].op    = isa_pkg::OP_ADD;
		slot[0].rs    = 5'd1;
		slot[0].rt    = 5'd2;
		slot[0].rd    = 5'd3;
		slot[1]       = '0;
		slot[1].valid = 1'b1;
		slot[1].op    = isa_pkg::OP_ADDI;
		slot[1].rs    = 5'd2;
		slot[1].rt    = 5'd1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		for (int cyc = 0; cyc < n_cycles; cyc++) begin
			@(negedge clk);
			fetch_entry[0]     = encode(slot[0]);
			fetch_entry[1]     = encode(slot[1]);
			delayslot_not_exec = next_ds;
			#1;
			predict();
			check_value("stall_req", 64'(stall_req), 64'(exp_stall));
			check_value("issue_num", 64'(issue_num), 64'(exp_num));
			check_value("issue_instr", 64'(issue_instr), 64'(exp_instr));
			advance();
			next_inputs();
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: flist.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/instr_decode.sv
src/instr_issue.sv
src/pipe_tracker.sv
src/issue_stage.sv
verif/issue_stage_properties.sv
verif/issue_stage_tb.sv

// File: Makefile
TOP := issue_stage_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f flist.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
